// ==== logic/dma_rd_pkg.sv ====
// shared constants, scalar types, queue entry and FSM state enums
// for the unaligned read DMA engine
`default_nettype none

package dma_rd_pkg;

    //////////////////////////////////////////////////
    // bus and length constants
    //////////////////////////////////////////////////
    localparam int DATA_W          = 32;
    localparam int STRB_W          = 4;
    localparam int OFFSET_W        = 2;
    localparam int BEAT_SHIFT      = 2;
    localparam int ADDR_W          = 16;
    localparam int LEN_W           = 20;
    localparam int MAX_BURST_LEN   = 16;
    localparam int MAX_BURST_BYTES = MAX_BURST_LEN * STRB_W;
    localparam int PAGE_BYTES      = 4096;
    localparam int CYCLE_W         = LEN_W - BEAT_SHIFT + 1;
    localparam int CMD_DEPTH       = 4;

    typedef logic [ADDR_W-1:0]   addr_t;
    typedef logic [LEN_W-1:0]    len_t;
    typedef logic [DATA_W-1:0]   data_t;
    typedef logic [STRB_W-1:0]   keep_t;
    typedef logic [7:0]          arlen_t;
    typedef logic [OFFSET_W-1:0] offset_t;
    typedef logic [CYCLE_W-1:0]  cycles_t;

    // beat counts are stored as count minus one
    typedef struct packed {
        offset_t shift_offset;
        offset_t last_bytes;
        logic    bubble;
        cycles_t in_beats;
        cycles_t out_beats;
    } realign_cmd_t;

    typedef enum logic {SPLIT_IDLE, SPLIT_ISSUE} split_state_t;
    typedef enum logic {ALIGN_IDLE, ALIGN_READ} align_state_t;

endpackage

`default_nettype wire

// ==== logic/dma_rd_burst_splitter.sv ====
// descriptor intake and read address generation
// builds one realignment command per descriptor and splits the
// transfer into bursts of at most 16 beats that never cross a 4 KB page
`default_nettype none

module dma_rd_burst_splitter (
    input  wire                            aclk,
    input  wire                            aresetn,
    input  wire dma_rd_pkg::addr_t         desc_addr,
    input  wire dma_rd_pkg::len_t          desc_len,
    input  wire                            desc_valid,
    output logic                           desc_ready,
    output logic                           cmd_in_valid,
    output dma_rd_pkg::realign_cmd_t       cmd_in_data,
    input  wire                            cmd_in_ready,
    output dma_rd_pkg::addr_t              araddr,
    output dma_rd_pkg::arlen_t             arlen,
    output logic                           arvalid,
    input  wire                            arready
);

    dma_rd_pkg::split_state_t state;
    dma_rd_pkg::addr_t        addr_reg;
    dma_rd_pkg::addr_t        src_addr;
    dma_rd_pkg::len_t         rem_reg;
    dma_rd_pkg::len_t         src_rem;
    dma_rd_pkg::len_t         bytes;
    dma_rd_pkg::len_t         page_left;
    dma_rd_pkg::offset_t      lane;
    logic                     idle;
    logic                     accept;
    logic                     load;
    logic                     run;

    assign idle       = (state == dma_rd_pkg::SPLIT_IDLE);
    // no descriptor is taken in the first cycle after reset
    assign desc_ready = idle && cmd_in_ready && run;
    assign accept     = desc_valid && desc_ready;
    // command goes into the queue in the same cycle the descriptor is taken
    assign cmd_in_valid = idle && desc_valid && run;

    // the first burst comes straight from the descriptor
    assign src_addr = idle ? desc_addr : addr_reg;
    assign src_rem  = idle ? desc_len : rem_reg;
    assign lane     = src_addr[dma_rd_pkg::OFFSET_W-1:0];
    assign load     = accept || (!idle && !arvalid);

    //////////////////////////////////////////////////
    // burst size
    //////////////////////////////////////////////////
    always_comb begin
        bytes = dma_rd_pkg::len_t'(dma_rd_pkg::MAX_BURST_BYTES - int'(lane));
        if (src_rem < bytes) begin
            bytes = src_rem;
        end
        // stop at the next page boundary
        page_left = dma_rd_pkg::len_t'(dma_rd_pkg::PAGE_BYTES
                                      - int'(src_addr % dma_rd_pkg::PAGE_BYTES));
        if (page_left < bytes) begin
            bytes = page_left;
        end
    end

    always_comb begin
        cmd_in_data.shift_offset = dma_rd_pkg::offset_t'(dma_rd_pkg::STRB_W - int'(lane));
        cmd_in_data.last_bytes   = desc_len[dma_rd_pkg::OFFSET_W-1:0];
        cmd_in_data.bubble       = (lane != '0);
        cmd_in_data.in_beats     = dma_rd_pkg::cycles_t'(({1'b0, desc_len} + lane - 1'b1)
                                                         >> dma_rd_pkg::BEAT_SHIFT);
        cmd_in_data.out_beats    = dma_rd_pkg::cycles_t'((desc_len - 1'b1)
                                                         >> dma_rd_pkg::BEAT_SHIFT);
    end

    //////////////////////////////////////////////////
    // address channel FSM
    //////////////////////////////////////////////////
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            state   <= dma_rd_pkg::SPLIT_IDLE;
            arvalid <= 1'b0;
            run     <= 1'b0;
        end else begin
            run <= 1'b1;
            case (state)
                dma_rd_pkg::SPLIT_IDLE: begin
                    if (accept) begin
                        arvalid <= 1'b1;
                        state   <= dma_rd_pkg::SPLIT_ISSUE;
                    end
                end
                dma_rd_pkg::SPLIT_ISSUE: begin
                    if (arvalid && arready) begin
                        arvalid <= 1'b0;
                        // nothing left after this burst
                        if (rem_reg == '0) begin
                            state <= dma_rd_pkg::SPLIT_IDLE;
                        end
                    end else if (!arvalid) begin
                        arvalid <= 1'b1;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge aclk) begin
        if (load) begin
            araddr   <= src_addr;
            arlen    <= dma_rd_pkg::arlen_t'((bytes + lane - 1'b1) >> dma_rd_pkg::BEAT_SHIFT);
            addr_reg <= src_addr + dma_rd_pkg::addr_t'(bytes);
            rem_reg  <= src_rem - bytes;
        end
    end

endmodule

`default_nettype wire

// ==== logic/dma_rd_cmd_fifo.sv ====
// register FIFO for realignment commands
// keeps descriptor order between address issue and data return
`default_nettype none

module dma_rd_cmd_fifo #(
    parameter int DEPTH = 4
) (
    input  wire                            aclk,
    input  wire                            aresetn,
    input  wire                            cmd_in_valid,
    input  wire dma_rd_pkg::realign_cmd_t  cmd_in_data,
    output logic                           cmd_in_ready,
    output logic                           cmd_out_valid,
    output dma_rd_pkg::realign_cmd_t       cmd_out_data,
    input  wire                            cmd_out_ready
);

    dma_rd_pkg::realign_cmd_t    mem [DEPTH];
    // one extra bit tells full from empty
    logic [$clog2(DEPTH):0]      wr_ptr;
    logic [$clog2(DEPTH):0]      rd_ptr;

    assign cmd_out_valid = (wr_ptr != rd_ptr);
    assign cmd_in_ready  = !((wr_ptr[$clog2(DEPTH)] != rd_ptr[$clog2(DEPTH)])
                             && (wr_ptr[$clog2(DEPTH)-1:0] == rd_ptr[$clog2(DEPTH)-1:0]));
    assign cmd_out_data  = mem[rd_ptr[$clog2(DEPTH)-1:0]];

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (cmd_in_valid && cmd_in_ready) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (cmd_out_valid && cmd_out_ready) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (cmd_in_valid && cmd_in_ready) begin
            mem[wr_ptr[$clog2(DEPTH)-1:0]] <= cmd_in_data;
        end
    end

endmodule

`default_nettype wire

// ==== logic/dma_rd_realign.sv ====
// read data FSM and byte realigner
// shifts returned beats down to lane 0, counts input and output beats,
// trims tkeep on the final beat and pulses status per descriptor
`default_nettype none

module dma_rd_realign (
    input  wire                            aclk,
    input  wire                            aresetn,
    input  wire                            cmd_out_valid,
    input  wire dma_rd_pkg::realign_cmd_t  cmd_out_data,
    output logic                           cmd_out_ready,
    input  wire dma_rd_pkg::data_t         rdata,
    input  wire                            rvalid,
    output logic                           rready,
    output logic                           beat_valid,
    output dma_rd_pkg::data_t              beat_data,
    output dma_rd_pkg::keep_t              beat_keep,
    output logic                           beat_last,
    input  wire                            beat_accept,
    input  wire                            beat_ready_early,
    output logic                           status_valid
);

    dma_rd_pkg::align_state_t          state;
    dma_rd_pkg::offset_t               shift_offset;
    dma_rd_pkg::offset_t               last_bytes;
    dma_rd_pkg::cycles_t               in_cnt;
    dma_rd_pkg::cycles_t               out_cnt;
    dma_rd_pkg::data_t                 prev_data;
    logic [2*dma_rd_pkg::DATA_W-1:0]   joined;
    logic                              in_active;
    logic                              in_more;
    logic                              out_last;
    logic                              bubble;
    logic                              rx;
    logic                              step;

    assign cmd_out_ready = (state == dma_rd_pkg::ALIGN_IDLE);
    assign rx            = rready && rvalid;
    // a beat slot advances once the input side is drained or has data
    assign step    = (state == dma_rd_pkg::ALIGN_READ) && beat_accept && (rx || !in_active);
    assign in_more = in_active && (in_cnt != '0);

    //////////////////////////////////////////////////
    // realign datapath
    //////////////////////////////////////////////////
    // drop the STRB_W - shift_offset leading lanes of the previous beat
    assign joined = {rdata, prev_data} >> ((dma_rd_pkg::STRB_W - int'(shift_offset))
                                          * (dma_rd_pkg::DATA_W / dma_rd_pkg::STRB_W));

    assign beat_valid = step && !bubble;
    assign beat_data  = joined[dma_rd_pkg::DATA_W-1:0];
    assign beat_last  = out_last;
    // a remainder of zero means the last beat is full
    assign beat_keep  = (out_last && last_bytes != '0)
                        ? dma_rd_pkg::keep_t'((1 << last_bytes) - 1) : '1;

    //////////////////////////////////////////////////
    // control FSM
    //////////////////////////////////////////////////
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            state        <= dma_rd_pkg::ALIGN_IDLE;
            rready       <= 1'b0;
            status_valid <= 1'b0;
        end else begin
            status_valid <= 1'b0;
            case (state)
                dma_rd_pkg::ALIGN_IDLE: begin
                    if (cmd_out_valid) begin
                        state  <= dma_rd_pkg::ALIGN_READ;
                        rready <= beat_ready_early;
                    end
                end
                dma_rd_pkg::ALIGN_READ: begin
                    if (step && !bubble && out_last) begin
                        state        <= dma_rd_pkg::ALIGN_IDLE;
                        rready       <= 1'b0;
                        status_valid <= 1'b1;
                    end else if (step) begin
                        rready <= beat_ready_early && in_more;
                    end else begin
                        rready <= beat_ready_early && in_active;
                    end
                end
            endcase
        end
    end

    // command fields and beat counters
    always_ff @(posedge aclk) begin
        if (cmd_out_valid && cmd_out_ready) begin
            shift_offset <= cmd_out_data.shift_offset;
            last_bytes   <= cmd_out_data.last_bytes;
            bubble       <= cmd_out_data.bubble;
            in_cnt       <= cmd_out_data.in_beats;
            out_cnt      <= cmd_out_data.out_beats;
            in_active    <= 1'b1;
            out_last     <= (cmd_out_data.out_beats == '0);
        end else if (step) begin
            if (rx) begin
                prev_data <= rdata;
            end
            if (in_active) begin
                in_cnt    <= in_cnt - 1'b1;
                in_active <= in_more;
            end
            // the bubble beat is captured only, no output consumed
            if (!bubble) begin
                out_cnt  <= out_cnt - 1'b1;
                out_last <= (out_cnt == dma_rd_pkg::cycles_t'(1));
            end
            bubble <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== logic/dma_rd_skid_buffer.sv ====
// two-entry registered output stage for the stream
// output register plus a temporary register behind it
`default_nettype none

module dma_rd_skid_buffer (
    input  wire                     aclk,
    input  wire                     aresetn,
    input  wire                     beat_valid,
    input  wire dma_rd_pkg::data_t  beat_data,
    input  wire dma_rd_pkg::keep_t  beat_keep,
    input  wire                     beat_last,
    output logic                    beat_accept,
    output logic                    beat_ready_early,
    output dma_rd_pkg::data_t       tdata,
    output dma_rd_pkg::keep_t       tkeep,
    output logic                    tlast,
    output logic                    tvalid,
    input  wire                     tready
);

    dma_rd_pkg::data_t  temp_data;
    dma_rd_pkg::keep_t  temp_keep;
    logic               temp_last;
    logic               temp_valid;
    logic               store_out;
    logic               store_temp;
    logic               temp_to_out;

    // ready next cycle unless the temp entry could end up filled
    assign beat_ready_early = tready || (!temp_valid && (!tvalid || !beat_valid));

    always_comb begin
        store_out   = beat_accept && (tready || !tvalid);
        store_temp  = beat_accept && !tready && tvalid;
        temp_to_out = !beat_accept && tready;
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            tvalid      <= 1'b0;
            temp_valid  <= 1'b0;
            beat_accept <= 1'b0;
        end else begin
            beat_accept <= beat_ready_early;
            if (store_out) begin
                tvalid <= beat_valid;
            end else if (store_temp) begin
                temp_valid <= beat_valid;
            end else if (temp_to_out) begin
                tvalid     <= temp_valid;
                temp_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (store_out) begin
            tdata <= beat_data;
            tkeep <= beat_keep;
            tlast <= beat_last;
        end else if (temp_to_out) begin
            tdata <= temp_data;
            tkeep <= temp_keep;
            tlast <= temp_last;
        end
        if (store_temp) begin
            temp_data <= beat_data;
            temp_keep <= beat_keep;
            temp_last <= beat_last;
        end
    end

endmodule

`default_nettype wire

// ==== logic/dma_rd_engine.sv ====
// top level of the unaligned read DMA engine
// splitter -> command FIFO -> realigner -> skid buffer
`default_nettype none

module dma_rd_engine (
    input  wire                     aclk,
    input  wire                     aresetn,
    input  wire dma_rd_pkg::addr_t  desc_addr,
    input  wire dma_rd_pkg::len_t   desc_len,
    input  wire                     desc_valid,
    output logic                    desc_ready,
    output dma_rd_pkg::addr_t       araddr,
    output dma_rd_pkg::arlen_t      arlen,
    output logic                    arvalid,
    input  wire                     arready,
    input  wire dma_rd_pkg::data_t  rdata,
    // beat counting comes from the command, rlast is not needed here
    input  wire                     rlast,
    input  wire                     rvalid,
    output logic                    rready,
    output dma_rd_pkg::data_t       tdata,
    output dma_rd_pkg::keep_t       tkeep,
    output logic                    tlast,
    output logic                    tvalid,
    input  wire                     tready,
    output logic                    status_valid
);

    logic                      cmd_in_valid;
    logic                      cmd_in_ready;
    dma_rd_pkg::realign_cmd_t  cmd_in_data;
    logic                      cmd_out_valid;
    logic                      cmd_out_ready;
    dma_rd_pkg::realign_cmd_t  cmd_out_data;
    logic                      beat_valid;
    dma_rd_pkg::data_t         beat_data;
    dma_rd_pkg::keep_t         beat_keep;
    logic                      beat_last;
    logic                      beat_accept;
    logic                      beat_ready_early;

    dma_rd_burst_splitter i_dma_rd_burst_splitter (
        .aclk         (aclk),
        .aresetn      (aresetn),
        .desc_addr    (desc_addr),
        .desc_len     (desc_len),
        .desc_valid   (desc_valid),
        .desc_ready   (desc_ready),
        .cmd_in_valid (cmd_in_valid),
        .cmd_in_data  (cmd_in_data),
        .cmd_in_ready (cmd_in_ready),
        .araddr       (araddr),
        .arlen        (arlen),
        .arvalid      (arvalid),
        .arready      (arready)
    );

    dma_rd_cmd_fifo #(
        .DEPTH (dma_rd_pkg::CMD_DEPTH)
    ) i_dma_rd_cmd_fifo (
        .aclk          (aclk),
        .aresetn       (aresetn),
        .cmd_in_valid  (cmd_in_valid),
        .cmd_in_data   (cmd_in_data),
        .cmd_in_ready  (cmd_in_ready),
        .cmd_out_valid (cmd_out_valid),
        .cmd_out_data  (cmd_out_data),
        .cmd_out_ready (cmd_out_ready)
    );

    dma_rd_realign i_dma_rd_realign (
        .aclk             (aclk),
        .aresetn          (aresetn),
        .cmd_out_valid    (cmd_out_valid),
        .cmd_out_data     (cmd_out_data),
        .cmd_out_ready    (cmd_out_ready),
        .rdata            (rdata),
        .rvalid           (rvalid),
        .rready           (rready),
        .beat_valid       (beat_valid),
        .beat_data        (beat_data),
        .beat_keep        (beat_keep),
        .beat_last        (beat_last),
        .beat_accept      (beat_accept),
        .beat_ready_early (beat_ready_early),
        .status_valid     (status_valid)
    );

    dma_rd_skid_buffer i_dma_rd_skid_buffer (
        .aclk             (aclk),
        .aresetn          (aresetn),
        .beat_valid       (beat_valid),
        .beat_data        (beat_data),
        .beat_keep        (beat_keep),
        .beat_last        (beat_last),
        .beat_accept      (beat_accept),
        .beat_ready_early (beat_ready_early),
        .tdata            (tdata),
        .tkeep            (tkeep),
        .tlast            (tlast),
        .tvalid           (tvalid),
        .tready           (tready)
    );

endmodule

`default_nettype wire

// ==== dv/dma_rd_assertions.sv ====
// protocol assertions for the read DMA engine
// address and stream channel stability, burst limits, reset values
`default_nettype none

module dma_rd_assertions (
    input wire                     aclk,
    input wire                     aresetn,
    input wire                     desc_ready,
    input wire dma_rd_pkg::addr_t  araddr,
    input wire dma_rd_pkg::arlen_t arlen,
    input wire                     arvalid,
    input wire                     arready,
    input wire                     rlast,
    input wire                     rvalid,
    input wire                     rready,
    input wire dma_rd_pkg::data_t  tdata,
    input wire dma_rd_pkg::keep_t  tkeep,
    input wire                     tlast,
    input wire                     tvalid,
    input wire                     tready,
    input wire                     status_valid
);

    // request is held until the slave takes it
    ar_hold: assert property (@(posedge aclk) disable iff (!aresetn)
        arvalid && !arready |=> arvalid && $stable(araddr) && $stable(arlen))
        else $error("read address request changed before arready");

    ar_page: assert property (@(posedge aclk) disable iff (!aresetn)
        arvalid |-> (int'(araddr[11:0] & 12'hffc) + 4 * (int'(arlen) + 1)
                     <= dma_rd_pkg::PAGE_BYTES))
        else $error("read burst at %h crosses a 4 KB page", araddr);

    ar_len: assert property (@(posedge aclk) disable iff (!aresetn)
        arvalid |-> arlen < 8'd16)
        else $error("read burst length %0d above 16 beats", int'(arlen) + 1);

    r_last: assert property (@(posedge aclk) disable iff (!aresetn)
        rlast |-> rvalid)
        else $error("rlast raised without rvalid");

    t_hold: assert property (@(posedge aclk) disable iff (!aresetn)
        tvalid && !tready |=> tvalid && $stable(tdata) && $stable(tkeep) && $stable(tlast))
        else $error("stream beat changed while tready was low");

    reset_low: assert property (@(posedge aclk)
        !aresetn |=> !desc_ready && !arvalid && !rready && !tvalid && !status_valid)
        else $error("control outputs not low after reset");

endmodule

bind dma_rd_engine dma_rd_assertions i_dma_rd_assertions (.*);

`default_nettype wire

// ==== dv/dma_rd_tb.sv ====
// testbench for the unaligned read DMA engine
// descriptor driver from a data file, memory-model read slave,
// stream checker and cycle timeout
`default_nettype none

module dma_rd_tb;

    localparam int MAX_DESC = 64;

    logic                aclk;
    logic                aresetn = 1'b0;
    dma_rd_pkg::addr_t   desc_addr = '0;
    dma_rd_pkg::len_t    desc_len = '0;
    logic                desc_valid = 1'b0;
    logic                desc_ready;
    dma_rd_pkg::addr_t   araddr;
    dma_rd_pkg::arlen_t  arlen;
    logic                arvalid;
    logic                arready = 1'b0;
    dma_rd_pkg::data_t   rdata = '0;
    logic                rlast = 1'b0;
    logic                rvalid = 1'b0;
    logic                rready;
    dma_rd_pkg::data_t   tdata;
    dma_rd_pkg::keep_t   tkeep;
    logic                tlast;
    logic                tvalid;
    logic                tready = 1'b0;
    logic                status_valid;

    int          desc_count = 0;
    int          addr_list [MAX_DESC];
    int          len_list [MAX_DESC];
    int          cycle_limit = 0;
    int          cycle_cnt = 0;
    int unsigned rand_state = 68323;
    // memory model state
    int          beat_q [$];
    logic        last_q [$];
    int          ar_desc = 0;
    int          ar_next = 0;
    // stream checker state
    int          out_desc = 0;
    int          out_pos = 0;
    int          status_cnt = 0;
    int          accept_cnt = 0;
    logic        overlap_seen = 1'b0;

    dma_rd_engine i_dma_rd_engine (.*);

    initial begin
        aclk = 1'b0;
        forever begin
            #10 aclk = ~aclk;
        end
    end

    function automatic int unsigned next_random();
        rand_state = rand_state * 32'd1664525 + 32'd1013904223;
        return rand_state >> 16;
    endfunction

    // memory contents are the low address byte xor the high address byte
    function automatic logic [7:0] pattern_byte(int addr);
        return addr[7:0] ^ addr[15:8];
    endfunction

    //////////////////////////////////////////////////
    // error reporting and compare tasks
    //////////////////////////////////////////////////
    task automatic stop_with_error(string what);
        $display("%s", what);
        $display("ERRORS FOUND");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_data(string name, dma_rd_pkg::data_t expected,
                              dma_rd_pkg::data_t actual, dma_rd_pkg::keep_t mask);
        dma_rd_pkg::data_t lanes;
        for (int j = 0; j < dma_rd_pkg::STRB_W; j++) begin
            lanes[8*j +: 8] = {8{mask[j]}};
        end
        if ((expected & lanes) !== (actual & lanes)) begin
            stop_with_error($sformatf("[FAIL] %0t %s expected %h got %h", $time, name,
                                      expected & lanes, actual & lanes));
        end
    endtask

    task automatic check_keep(string name, dma_rd_pkg::keep_t expected,
                              dma_rd_pkg::keep_t actual);
        if (expected !== actual) begin
            stop_with_error($sformatf("[FAIL] %0t %s expected %b got %b", $time, name,
                                      expected, actual));
        end
    endtask

    task automatic check_last(string name, logic expected, logic actual);
        if (expected !== actual) begin
            stop_with_error($sformatf("[FAIL] %0t %s expected %b got %b", $time, name,
                                      expected, actual));
        end
    endtask

    task automatic check_count(string name, dma_rd_pkg::len_t expected,
                               dma_rd_pkg::len_t actual);
        if (expected !== actual) begin
            stop_with_error($sformatf("[FAIL] %0t %s expected %0d got %0d", $time, name,
                                      expected, actual));
        end
    endtask

    task automatic check_addr(string name, dma_rd_pkg::addr_t expected,
                              dma_rd_pkg::addr_t actual);
        if (expected !== actual) begin
            stop_with_error($sformatf("[FAIL] %0t %s expected %h got %h", $time, name,
                                      expected, actual));
        end
    endtask

    //////////////////////////////////////////////////
    // read slave with random handshakes on every channel
    //////////////////////////////////////////////////
    always @(posedge aclk) begin
        int base;
        int beats;
        int last_beat;
        dma_rd_pkg::data_t word;
        if (!aresetn) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
            rlast   <= 1'b0;
            tready  <= 1'b0;
        end else begin
            if (arvalid && arready) begin
                base  = int'(araddr) & ~3;
                beats = int'(arlen) + 1;
                if (ar_desc >= desc_count) begin
                    stop_with_error("read burst issued with no descriptor left");
                end
                check_addr("araddr", dma_rd_pkg::addr_t'(ar_next), araddr);
                if (beats > dma_rd_pkg::MAX_BURST_LEN) begin
                    stop_with_error($sformatf("burst at %h has %0d beats", araddr, beats));
                end
                if (base / 4096 != (base + 4 * beats - 1) / 4096) begin
                    stop_with_error($sformatf("burst at %h crosses a 4 KB page", araddr));
                end
                for (int j = 0; j < beats; j++) begin
                    beat_q.push_back(base + 4 * j);
                    last_q.push_back(j == beats - 1);
                end
                ar_next   = base + 4 * beats;
                last_beat = (addr_list[ar_desc] + len_list[ar_desc] - 1) & ~3;
                // once a descriptor is covered the next one starts at its own address
                if (ar_next > last_beat) begin
                    if (ar_next != last_beat + 4) begin
                        stop_with_error($sformatf("bursts overrun descriptor %0d", ar_desc));
                    end
                    ar_desc = ar_desc + 1;
                    if (ar_desc < desc_count) begin
                        ar_next = addr_list[ar_desc];
                    end
                end
            end
            arready <= (next_random() % 4) != 0;
            tready  <= (next_random() % 3) != 0;
            if (!rvalid || rready) begin
                if (beat_q.size() > 0 && (next_random() % 4) != 0) begin
                    base = beat_q.pop_front();
                    for (int j = 0; j < dma_rd_pkg::STRB_W; j++) begin
                        word[8*j +: 8] = pattern_byte(base + j);
                    end
                    rdata  <= word;
                    rlast  <= last_q.pop_front();
                    rvalid <= 1'b1;
                end else begin
                    rvalid <= 1'b0;
                    rlast  <= 1'b0;
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // stream and status checker
    //////////////////////////////////////////////////
    always @(posedge aclk) begin
        dma_rd_pkg::data_t exp_data;
        dma_rd_pkg::keep_t exp_keep;
        logic exp_last;
        int left;
        if (aresetn) begin
            // status is counted first since it may come in the same cycle as tlast
            if (status_valid) begin
                status_cnt = status_cnt + 1;
            end
            if (desc_valid && desc_ready) begin
                accept_cnt = accept_cnt + 1;
            end
            if (tvalid && tready) begin
                if (out_desc >= desc_count) begin
                    stop_with_error("stream beat after the last descriptor");
                end
                left     = len_list[out_desc] - out_pos;
                exp_last = (left <= dma_rd_pkg::STRB_W);
                exp_keep = exp_last ? dma_rd_pkg::keep_t'((1 << left) - 1) : '1;
                exp_data = '0;
                for (int j = 0; j < dma_rd_pkg::STRB_W; j++) begin
                    if (j < left) begin
                        exp_data[8*j +: 8] = pattern_byte(addr_list[out_desc] + out_pos + j);
                    end
                end
                check_keep("tkeep", exp_keep, tkeep);
                check_last("tlast", exp_last, tlast);
                check_data("tdata", exp_data, tdata, exp_keep);
                out_pos = out_pos + dma_rd_pkg::STRB_W;
                if (exp_last) begin
                    if (status_cnt < out_desc + 1) begin
                        stop_with_error($sformatf("no status pulse for descriptor %0d by its tlast",
                                                  out_desc));
                    end
                    if (accept_cnt > out_desc + 1) begin
                        overlap_seen = 1'b1;
                    end
                    out_desc = out_desc + 1;
                    out_pos  = 0;
                end
            end
        end
    end

    always @(posedge aclk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_limit != 0 && cycle_cnt >= cycle_limit) begin
            stop_with_error($sformatf("run timed out after %0d cycles", cycle_cnt));
        end
    end

    //////////////////////////////////////////////////
    // test data, reset and descriptor driver
    //////////////////////////////////////////////////
    initial begin
        int fd;
        int a;
        int l;
        int beats;
        logic [8*100-1:0] header_line;
        beats = 0;
        fd = $fopen("dv/dma_rd_testdata.txt", "r");
        if (fd == 0) begin
            stop_with_error("cannot open dv/dma_rd_testdata.txt");
        end
        void'($fgets(header_line, fd));
        if ($fscanf(fd, "%d", desc_count) != 1 || desc_count < 1 || desc_count > MAX_DESC) begin
            stop_with_error("descriptor count in the test data is missing or out of range");
        end
        for (int i = 0; i < desc_count; i++) begin
            if ($fscanf(fd, "%h %d", a, l) != 2) begin
                stop_with_error("a descriptor line is missing in the test data");
            end
            addr_list[i] = a;
            len_list[i]  = l;
            beats        = beats + (l + 3) / 4;
        end
        $fclose(fd);
        ar_next     = addr_list[0];
        cycle_limit = 200 + 30 * beats + 40 * desc_count;

        aresetn <= 1'b0;
        repeat (4) @(posedge aclk);
        aresetn <= 1'b1;

        // the next descriptor goes out on the accepting edge
        for (int i = 0; i < desc_count; i++) begin
            @(posedge aclk);
            desc_addr  <= dma_rd_pkg::addr_t'(addr_list[i]);
            desc_len   <= dma_rd_pkg::len_t'(len_list[i]);
            desc_valid <= 1'b1;
            @(negedge aclk);
            while (!desc_ready) begin
                @(negedge aclk);
            end
        end
        @(posedge aclk);
        desc_valid <= 1'b0;

        wait (out_desc == desc_count);
        repeat (4) @(posedge aclk);
        check_count("status_valid pulses", dma_rd_pkg::len_t'(desc_count),
                    dma_rd_pkg::len_t'(status_cnt));
        if (ar_desc != desc_count) begin
            stop_with_error("read bursts did not cover every descriptor");
        end
        if (!overlap_seen) begin
            stop_with_error("no descriptor was accepted before the previous tlast");
        end
        $display("NO ERRORS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== dv/dma_rd_testdata.txt ====
# columns: start byte address (hex), length in bytes (decimal); count line first
12
0000 64
0001 1
0003 3
0102 300
0ff5 40
1ffe 7
2003 128
2fc1 150
3000 4
4a06 255
5fff 2
6111 77

// ==== filelist.f ====
logic/dma_rd_pkg.sv
logic/dma_rd_burst_splitter.sv
logic/dma_rd_cmd_fifo.sv
logic/dma_rd_realign.sv
logic/dma_rd_skid_buffer.sv
logic/dma_rd_engine.sv
dv/dma_rd_assertions.sv
dv/dma_rd_tb.sv

// ==== run.sh ====
#!/bin/bash
# build and run the read DMA testbench with Verilator
set -o pipefail
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal --top-module dma_rd_tb \
    -f filelist.f -o dma_rd_sim \
    || { echo "verilator build failed"; exit 1; }

./obj_dir/dma_rd_sim 2>&1 | tee sim.log \
    || { echo "simulation exited with an error"; exit 1; }

grep -q "ERRORS FOUND" sim.log && { echo "simulation failed"; exit 1; } || exit 0
